// ==== src/ccip_pkg.sv ====
// Offsets on the host port count 64-bit words; the window maps each word to 4 bytes
// Tag and data widths here must match the host port; Avalon side is single beat
package ccip_pkg;

  // ************************************************************
  // Widths
  // ************************************************************
  localparam int TAG_W  = 9;   // Host transaction id
  localparam int OFS_W  = 16;  // MMIO word offset
  localparam int DATA_W = 64;  // MMIO and Avalon data
  localparam int ADDR_W = 32;  // Avalon byte address

  // ************************************************************
  // Register map
  // ************************************************************
  localparam logic [DATA_W-1:0] AFU_ID      = 64'hC0DE_5EED_A1F0_0001;  // Read at offset 0
  localparam logic [OFS_W-1:0]  SCRATCH_OFS = 16'h0002;
  localparam logic [OFS_W-1:0]  WIN_BASE    = 16'h0100;  // First offset routed to Avalon

  // One MMIO request from the host
  typedef struct packed {
    logic              valid;
    logic              write;   // 1 = write, 0 = read
    logic [OFS_W-1:0]  offset;
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] data;    // Write data, don't care on reads
  } mmio_req_t;

  // MMIO read response to the host
  typedef struct packed {
    logic              valid;
    logic [TAG_W-1:0]  tag;     // Copied from the request
    logic [DATA_W-1:0] data;
  } mmio_rsp_t;

  // Host to AFU port
  typedef struct packed {
    mmio_req_t mmio;
    logic      rsp_credit_return;  // One pulse gives back one response credit
  } if_rx_t;

  // AFU to host port
  typedef struct packed {
    mmio_rsp_t mmio;
    logic      req_credit_return;  // One pulse gives back one request credit
  } if_tx_t;

  // Queued Avalon access
  typedef struct packed {
    logic              write;
    logic [TAG_W-1:0]  tag;
    logic [ADDR_W-1:0] addr;    // Byte address
    logic [DATA_W-1:0] data;
  } avm_req_t;

endpackage

// ==== src/req_fifo.sv ====
// Show-ahead FIFO, dout is the head entry whenever empty is low
// Push while full and pop while empty are ignored
module req_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 4
) (
  input  logic pClk,
  input  logic arst_n,
  input  logic soft_reset,
  input  logic push,
  input  T     din,
  input  logic pop,
  output T     dout,
  output logic empty,
  output logic full
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // Pointer width
  localparam int CW = $clog2(DEPTH + 1);                // Count width

  T              mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_push;
  logic          do_pop;

  // Wrap at DEPTH, which need not be a power of two
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
    return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign empty   = (count == '0);
  assign full    = (count == CW'(DEPTH));
  assign dout    = mem[rd_ptr];

  // Storage
  always_ff @(posedge pClk)
  begin
    if (do_push)
      mem[wr_ptr] <= din;
  end

  // ************************************************************
  // Pointers and fill count
  // ************************************************************
  always_ff @(posedge pClk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else if (soft_reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_inc(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

endmodule

// ==== src/mmio_decoder.sv ====
// Decode is combinational on the registered request; only the scratch register is state
// Unmapped local reads return 0, unmapped and ID writes are dropped
module mmio_decoder
  import ccip_pkg::*;
(
  input  logic      pClk,
  input  logic      arst_n,
  input  logic      soft_reset,
  input  mmio_req_t req,
  output logic      avm_push,
  output avm_req_t  avm_req,
  output mmio_rsp_t local_rsp
);

  logic [DATA_W-1:0] scratch;
  logic              in_win;    // Offset falls in the Avalon window
  logic [OFS_W-1:0]  win_ofs;   // Word offset inside the window
  logic [DATA_W-1:0] rd_data;   // Local read mux

  assign in_win  = (req.offset >= WIN_BASE);
  assign win_ofs = req.offset - WIN_BASE;

  // ************************************************************
  // Avalon window
  // ************************************************************
  assign avm_push = req.valid && in_win;  // Host has spent a credit for this one

  always_comb
  begin
    avm_req.write = req.write;
    avm_req.tag   = req.tag;
    // Word offset times 4 gives the byte address
    avm_req.addr  = {{(ADDR_W - OFS_W - 2){1'b0}}, win_ofs, 2'b00};
    avm_req.data  = req.data;
  end

  // ************************************************************
  // Local registers
  // ************************************************************
  always_ff @(posedge pClk or negedge arst_n)
  begin
    if (!arst_n)
      scratch <= '0;
    else if (soft_reset)
      scratch <= '0;
    else if (req.valid && req.write && !in_win && (req.offset == SCRATCH_OFS))
      scratch <= req.data;
  end

  always_comb
  begin
    case (req.offset)
      16'h0000:    rd_data = AFU_ID;   // Identifier is read only
      SCRATCH_OFS: rd_data = scratch;
      default:     rd_data = '0;       // Unmapped
    endcase
  end

  // Goes straight to the Tx register in the arbiter
  always_comb
  begin
    local_rsp.valid = req.valid && !req.write && !in_win;
    local_rsp.tag   = req.tag;
    local_rsp.data  = rd_data;
  end

endmodule

// ==== src/avmm_master.sv ====
// One access at a time, so read data comes back in tag order
// Slave must not return readdatavalid in the cycle that accepts the read
module avmm_master
  import ccip_pkg::*;
(
  input  logic              pClk,
  input  logic              arst_n,
  input  logic              soft_reset,
  // Request queue head
  input  avm_req_t          req,
  input  logic              req_empty,
  output logic              req_pop,
  // Read response queue
  input  logic              rsp_full,
  output logic              rsp_push,
  output mmio_rsp_t         rsp,
  // Avalon-MM
  input  logic              avs_waitrequest,
  input  logic [DATA_W-1:0] avs_readdata,
  input  logic              avs_readdatavalid,
  output logic [ADDR_W-1:0] avs_address,
  output logic [DATA_W-1:0] avs_writedata,
  output logic              avs_write,
  output logic              avs_read,
  output logic [7:0]        avs_byteenable
);

  typedef enum logic [1:0] {
    ST_IDLE,       // Waiting for a queued request
    ST_ISSUE,      // Command on the bus, held under waitrequest
    ST_WAIT_DATA   // Read accepted, waiting for readdatavalid
  } state_t;

  state_t           state;
  logic [TAG_W-1:0] tag_q;    // Tag of the access in flight
  logic             start;

  // Reads start only when the response has somewhere to go
  assign start = !req_empty && (req.write || !rsp_full);

  assign req_pop  = (state == ST_ISSUE) && !avs_waitrequest;   // Accepted by the slave
  assign rsp_push = (state == ST_WAIT_DATA) && avs_readdatavalid;

  always_comb
  begin
    rsp.valid = rsp_push;
    rsp.tag   = tag_q;
    rsp.data  = avs_readdata;
  end

  assign avs_byteenable = '1;  // Full 64-bit word every time

  // ************************************************************
  // Command FSM
  // ************************************************************
  always_ff @(posedge pClk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state     <= ST_IDLE;
      avs_read  <= 1'b0;
      avs_write <= 1'b0;
    end
    else if (soft_reset)
    begin
      state     <= ST_IDLE;
      avs_read  <= 1'b0;
      avs_write <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (start)
          begin
            avs_read  <= !req.write;
            avs_write <= req.write;
            state     <= ST_ISSUE;
          end
        end
        ST_ISSUE:
        begin
          if (!avs_waitrequest)
          begin
            avs_read  <= 1'b0;
            avs_write <= 1'b0;
            state     <= avs_read ? ST_WAIT_DATA : ST_IDLE;  // Writes are done here
          end
        end
        ST_WAIT_DATA:
        begin
          if (avs_readdatavalid)
            state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Address, data and tag stay put until the next start
  always_ff @(posedge pClk)
  begin
    if ((state == ST_IDLE) && start)
    begin
      avs_address   <= req.addr;
      avs_writedata <= req.data;
      tag_q         <= req.tag;
    end
  end

endmodule

// ==== src/tx_arbiter.sv ====
// Avalon responses win; one local response can wait, a second one before it drains is lost
// Host must not return more response credits than it was given
module tx_arbiter
  import ccip_pkg::*;
#(
  parameter int RSP_CREDITS = 2
) (
  input  logic      pClk,
  input  logic      arst_n,
  input  logic      soft_reset,
  input  mmio_rsp_t local_rsp,
  input  mmio_rsp_t avm_rsp,
  input  logic      avm_rsp_empty,
  output logic      avm_rsp_pop,
  input  logic      req_popped,         // Request queue entry consumed
  input  logic      rsp_credit_return,
  output if_tx_t    tx
);

  localparam int CW = $clog2(RSP_CREDITS + 1);

  logic [CW-1:0] credits;     // Response credits held by the AFU
  logic          hold_vld;
  mmio_rsp_t     hold_q;      // Local response waiting for its turn
  logic          loc_vld;
  mmio_rsp_t     loc_rsp;     // Local candidate, held entry first
  logic          can_send;
  logic          send_avm;
  logic          send_loc;

  // ************************************************************
  // Arbitration
  // ************************************************************
  assign loc_vld  = hold_vld || local_rsp.valid;
  assign loc_rsp  = hold_vld ? hold_q : local_rsp;
  assign can_send = (credits != '0);
  assign send_avm = can_send && !avm_rsp_empty;
  assign send_loc = can_send && !send_avm && loc_vld;

  assign avm_rsp_pop = send_avm;

  // Holding register
  always_ff @(posedge pClk or negedge arst_n)
  begin
    if (!arst_n)
      hold_vld <= 1'b0;
    else if (soft_reset)
      hold_vld <= 1'b0;
    else if (local_rsp.valid && (hold_vld || !send_loc))
      hold_vld <= 1'b1;   // New one could not bypass
    else if (send_loc)
      hold_vld <= 1'b0;
  end

  always_ff @(posedge pClk)
  begin
    if (local_rsp.valid && (hold_vld || !send_loc))
      hold_q <= local_rsp;
  end

  // Credit counter
  always_ff @(posedge pClk or negedge arst_n)
  begin
    if (!arst_n)
      credits <= CW'(RSP_CREDITS);
    else if (soft_reset)
      credits <= CW'(RSP_CREDITS);
    else
      credits <= credits - CW'(send_avm || send_loc) + CW'(rsp_credit_return);
  end

  // ************************************************************
  // Tx register
  // ************************************************************
  always_ff @(posedge pClk or negedge arst_n)
  begin
    if (!arst_n)
      tx <= '0;
    else if (soft_reset)
      tx <= '0;
    else
    begin
      tx.mmio.valid        <= send_avm || send_loc;
      tx.mmio.tag          <= send_avm ? avm_rsp.tag : loc_rsp.tag;
      tx.mmio.data         <= send_avm ? avm_rsp.data : loc_rsp.data;
      tx.req_credit_return <= req_popped;  // One pulse per popped entry
    end
  end

endmodule

// ==== src/afu.sv ====
// Interconnect only; the request queue relies on host credits and is never pushed full
module afu
  import ccip_pkg::*;
#(
  parameter int REQ_CREDITS = 4,
  parameter int RSP_CREDITS = 2
) (
  input  logic              pClk,
  input  logic              arst_n,
  input  logic              soft_reset,
  input  if_rx_t            rx,
  output if_tx_t            tx,
  input  logic              avs_waitrequest,
  input  logic [DATA_W-1:0] avs_readdata,
  input  logic              avs_readdatavalid,
  output logic [ADDR_W-1:0] avs_address,
  output logic [DATA_W-1:0] avs_writedata,
  output logic              avs_write,
  output logic              avs_read,
  output logic [7:0]        avs_byteenable
);

  logic      avm_push;       // Decoder to request queue
  avm_req_t  avm_req_in;
  avm_req_t  avm_req_head;   // Queue head seen by the master
  logic      req_empty;
  logic      req_pop;        // Also drives the request credit return
  mmio_rsp_t local_rsp;      // Local register read data
  logic      rsp_push;       // Master to read response queue
  mmio_rsp_t rsp_in;
  mmio_rsp_t avm_rsp;
  logic      avm_rsp_empty;
  logic      avm_rsp_full;
  logic      avm_rsp_pop;

  mmio_decoder i_mmio_decoder (
    .pClk       (pClk),
    .arst_n     (arst_n),
    .soft_reset (soft_reset),
    .req        (rx.mmio),
    .avm_push   (avm_push),
    .avm_req    (avm_req_in),
    .local_rsp  (local_rsp)
  );

  // Window request queue, depth equals host request credits
  req_fifo #(
    .T     (avm_req_t),
    .DEPTH (REQ_CREDITS)
  ) i_req_fifo (
    .pClk       (pClk),
    .arst_n     (arst_n),
    .soft_reset (soft_reset),
    .push       (avm_push),
    .din        (avm_req_in),
    .pop        (req_pop),
    .dout       (avm_req_head),
    .empty      (req_empty),
    .full       ()              // Credits bound the fill level
  );

  avmm_master i_avmm_master (
    .pClk              (pClk),
    .arst_n            (arst_n),
    .soft_reset        (soft_reset),
    .req               (avm_req_head),
    .req_empty         (req_empty),
    .req_pop           (req_pop),
    .rsp_full          (avm_rsp_full),
    .rsp_push          (rsp_push),
    .rsp               (rsp_in),
    .avs_waitrequest   (avs_waitrequest),
    .avs_readdata      (avs_readdata),
    .avs_readdatavalid (avs_readdatavalid),
    .avs_address       (avs_address),
    .avs_writedata     (avs_writedata),
    .avs_write         (avs_write),
    .avs_read          (avs_read),
    .avs_byteenable    (avs_byteenable)
  );

  // Read response queue, drains only while response credits last
  req_fifo #(
    .T     (mmio_rsp_t),
    .DEPTH (RSP_CREDITS)
  ) i_rsp_fifo (
    .pClk       (pClk),
    .arst_n     (arst_n),
    .soft_reset (soft_reset),
    .push       (rsp_push),
    .din        (rsp_in),
    .pop        (avm_rsp_pop),
    .dout       (avm_rsp),
    .empty      (avm_rsp_empty),
    .full       (avm_rsp_full)
  );

  tx_arbiter #(
    .RSP_CREDITS (RSP_CREDITS)
  ) i_tx_arbiter (
    .pClk              (pClk),
    .arst_n            (arst_n),
    .soft_reset        (soft_reset),
    .local_rsp         (local_rsp),
    .avm_rsp           (avm_rsp),
    .avm_rsp_empty     (avm_rsp_empty),
    .avm_rsp_pop       (avm_rsp_pop),
    .req_popped        (req_pop),
    .rsp_credit_return (rx.rsp_credit_return),
    .tx                (tx)
  );

endmodule

// ==== src/ccip_std_afu.sv ====
// All host inputs pass one register stage; soft reset acts as a synchronous clear
// below while arst_n stays asynchronous. Avalon accesses are single beat only
module ccip_std_afu
  import ccip_pkg::*;
#(
  parameter int REQ_CREDITS = 4,  // Request queue depth, host starts with this many
  parameter int RSP_CREDITS = 2   // Response credits the AFU starts with
) (
  input  logic              pClk,
  input  logic              arst_n,
  input  logic              soft_reset,         // Active high, from the host
  input  if_rx_t            rx,
  output if_tx_t            tx,
  // Avalon-MM master
  input  logic              avs_waitrequest,
  input  logic [DATA_W-1:0] avs_readdata,
  input  logic              avs_readdatavalid,
  output logic [ADDR_W-1:0] avs_address,
  output logic [DATA_W-1:0] avs_writedata,
  output logic              avs_write,
  output logic              avs_read,
  output logic [7:0]        avs_byteenable
);

  if_rx_t rx_q;          // Registered host port
  logic   soft_reset_q;  // Registered soft reset

  // ************************************************************
  // Boundary registers
  // ************************************************************
  always_ff @(posedge pClk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rx_q         <= '0;
      soft_reset_q <= 1'b0;
    end
    else
    begin
      rx_q         <= rx;
      soft_reset_q <= soft_reset;
    end
  end

  // Reset pair goes down together, every flop below honors both
  afu #(
    .REQ_CREDITS (REQ_CREDITS),
    .RSP_CREDITS (RSP_CREDITS)
  ) i_afu (
    .pClk              (pClk),
    .arst_n            (arst_n),
    .soft_reset        (soft_reset_q),
    .rx                (rx_q),
    .tx                (tx),
    .avs_waitrequest   (avs_waitrequest),
    .avs_readdata      (avs_readdata),
    .avs_readdatavalid (avs_readdatavalid),
    .avs_address       (avs_address),
    .avs_writedata     (avs_writedata),
    .avs_write         (avs_write),
    .avs_read          (avs_read),
    .avs_byteenable    (avs_byteenable)
  );

endmodule

// ==== dv/avmm_slave_model.sv ====
// Memory covers window word offsets 0x000..0x0FF only; other addresses or partial
// byteenable set bad_access. One read outstanding at a time, as the master issues them
module avmm_slave_model
  import ccip_pkg::*;
(
  input  logic              pClk,
  input  logic              arst_n,
  input  logic [ADDR_W-1:0] avs_address,
  input  logic [DATA_W-1:0] avs_writedata,
  input  logic              avs_write,
  input  logic              avs_read,
  input  logic [7:0]        avs_byteenable,
  output logic              avs_waitrequest,
  output logic [DATA_W-1:0] avs_readdata,
  output logic              avs_readdatavalid,
  output logic              bad_access        // Sticky
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [DATA_W-1:0] mem [256];   // Indexed by byte address bits 9:2
  logic [DATA_W-1:0] rd_q;        // Read data waiting out its latency
  logic [1:0]        lat;         // Extra cycles before readdatavalid
  logic              pending;

  initial
  begin
    void'($urandom(46738));   // Single seed for the run
    // Fill depends on the whole word index
    for (int i = 0; i < 256; i++)
      mem[i] = {8'(i), 24'hA5A5A5, ~8'(i), 24'h5A5A5A};
    avs_waitrequest   = 1'b1;
    avs_readdata      = '0;
    avs_readdatavalid = 1'b0;
    bad_access        = 1'b0;
    rd_q              = '0;
    lat               = '0;
    pending           = 1'b0;
    forever
    begin
      @(posedge pClk or negedge arst_n);
      if (!arst_n)
      begin
        avs_waitrequest   <= 1'b1;
        avs_readdatavalid <= 1'b0;
        pending           <= 1'b0;
      end
      else
      begin
        avs_readdatavalid <= 1'b0;
        avs_waitrequest   <= (($urandom % 4) == 0);   // Stall about one cycle in four
        // ************************************************************
        // Command accepted this edge
        // ************************************************************
        if ((avs_read || avs_write) && !avs_waitrequest)
        begin
          if ((avs_address[31:10] != '0) || (avs_address[1:0] != '0) || (avs_byteenable != '1))
            bad_access <= 1'b1;
          if (avs_write)
            mem[avs_address[9:2]] <= avs_writedata;
          else
          begin
            rd_q    <= mem[avs_address[9:2]];
            lat     <= 2'($urandom % 4);
            pending <= 1'b1;
          end
        end
        if (pending)
        begin
          if (lat == 2'd0)
          begin
            avs_readdatavalid <= 1'b1;
            avs_readdata      <= rd_q;
            pending           <= 1'b0;
          end
          else
            lat <= lat - 2'd1;
        end
      end
    end
  end

endmodule

// ==== dv/tb_ccip_std_afu.sv ====
// Host model tracks both credit pools itself and issues local reads one at a time
// Window offsets used stay in 0x100..0x1FF, the range the slave model maps
module tb_ccip_std_afu
  import ccip_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int REQ_CREDITS = 4;
  localparam int RSP_CREDITS = 2;
  localparam int TIMEOUT     = 500;   // Cycles allowed per wait loop
  localparam int N_STEPS     = 26;

  localparam logic [DATA_W-1:0] D_SCR = 64'h1234_5678_9ABC_DEF0;
  localparam logic [DATA_W-1:0] D_A   = 64'hA000_0000_0000_0100;
  localparam logic [DATA_W-1:0] D_B   = 64'hB0B0_1111_2222_0105;
  localparam logic [DATA_W-1:0] D_C   = 64'hCCCC_0000_FFFF_01FF;
  localparam logic [DATA_W-1:0] D_PAT = 64'h80A5_A5A5_7F5A_5A5A;  // Slave fill of word 0x80

  typedef enum logic [2:0] {OP_WR, OP_RD, OP_RDN, OP_RDQ, OP_DRAIN, OP_SRST} op_e;

  typedef struct packed {
    op_e               op;
    logic [OFS_W-1:0]  ofs;
    logic [DATA_W-1:0] data;    // Write data, or idle cycles for a drain
    logic [DATA_W-1:0] exp;     // Expected read data
  } step_t;

  logic              pClk;
  logic              arst_n;
  logic              soft_reset;
  if_rx_t            rx;
  if_tx_t            tx;
  logic              avs_waitrequest;
  logic [DATA_W-1:0] avs_readdata;
  logic              avs_readdatavalid;
  logic [ADDR_W-1:0] avs_address;
  logic [DATA_W-1:0] avs_writedata;
  logic              avs_write;
  logic              avs_read;
  logic [7:0]        avs_byteenable;
  logic              bad_access;

  step_t             steps [N_STEPS];
  mmio_rsp_t         rsp_q [$];        // Responses seen on Tx
  logic [TAG_W-1:0]  exp_tag_q [$];
  logic [DATA_W-1:0] exp_data_q [$];
  logic [TAG_W-1:0]  next_tag;
  int                errors;
  int                failed_steps;
  int                req_credits;      // Host request credits in hand
  int                rsp_credits;      // Response credits the AFU should hold
  int                req_pulses;
  int                win_reqs;
  bit                aborted;

  ccip_std_afu #(
    .REQ_CREDITS (REQ_CREDITS),
    .RSP_CREDITS (RSP_CREDITS)
  ) i_ccip_std_afu (
    .pClk              (pClk),
    .arst_n            (arst_n),
    .soft_reset        (soft_reset),
    .rx                (rx),
    .tx                (tx),
    .avs_waitrequest   (avs_waitrequest),
    .avs_readdata      (avs_readdata),
    .avs_readdatavalid (avs_readdatavalid),
    .avs_address       (avs_address),
    .avs_writedata     (avs_writedata),
    .avs_write         (avs_write),
    .avs_read          (avs_read),
    .avs_byteenable    (avs_byteenable)
  );

  avmm_slave_model i_slave (
    .pClk              (pClk),
    .arst_n            (arst_n),
    .avs_address       (avs_address),
    .avs_writedata     (avs_writedata),
    .avs_write         (avs_write),
    .avs_read          (avs_read),
    .avs_byteenable    (avs_byteenable),
    .avs_waitrequest   (avs_waitrequest),
    .avs_readdata      (avs_readdata),
    .avs_readdatavalid (avs_readdatavalid),
    .bad_access        (bad_access)
  );

  always #20 pClk = ~pClk;   // 40 ns period

  // ************************************************************
  // Tx monitor samples mid-cycle
  // ************************************************************
  always @(negedge pClk)
  begin
    if (arst_n)
    begin
      if (tx.mmio.valid)
      begin
        if (rsp_credits <= 0)
        begin
          errors++;
          $display("response sent at %0d ns while the AFU held no response credit", $time);
        end
        rsp_credits--;
        rsp_q.push_back(tx.mmio);
      end
      if (tx.req_credit_return)
      begin
        req_pulses++;
        if (req_credits >= REQ_CREDITS)
        begin
          errors++;
          $display("request credit returned at %0d ns with no request outstanding", $time);
        end
        else
          req_credits++;
      end
    end
  end

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("mismatch at %0d ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    aborted = 1'b1;
    $display("timeout: %s, gave up after %0d cycles", what, TIMEOUT);
  endtask

  // One request cycle on Rx; window requests spend a credit first
  task automatic send_req(input logic wr, input logic [OFS_W-1:0] ofs,
                          input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] exp);
    mmio_req_t r;
    int        n;
    n = 0;
    if (ofs >= WIN_BASE)
    begin
      while ((req_credits == 0) && (n < TIMEOUT))
      begin
        @(posedge pClk);
        n++;
      end
      if (req_credits == 0)
      begin
        report_timeout("no request credit came back");
        return;
      end
      req_credits--;
      win_reqs++;
    end
    r.valid  = 1'b1;
    r.write  = wr;
    r.offset = ofs;
    r.tag    = next_tag;
    r.data   = data;
    @(posedge pClk);
    rx.mmio <= r;
    @(posedge pClk);
    rx.mmio.valid <= 1'b0;
    if (!wr)
    begin
      exp_tag_q.push_back(next_tag);
      exp_data_q.push_back(exp);
    end
    next_tag++;
  endtask

  task automatic return_credit();
    @(posedge pClk);
    rx.rsp_credit_return <= 1'b1;
    rsp_credits++;
    @(posedge pClk);
    rx.rsp_credit_return <= 1'b0;
  endtask

  // Waits for every expected response, then compares them in order
  task automatic collect_rsps();
    int        n;
    mmio_rsp_t r;
    n = 0;
    while ((rsp_q.size() < exp_tag_q.size()) && (n < TIMEOUT))
    begin
      @(posedge pClk);
      n++;
    end
    if (rsp_q.size() < exp_tag_q.size())
    begin
      report_timeout("read response missing on Tx");
      return;
    end
    while (exp_tag_q.size() > 0)
    begin
      r = rsp_q.pop_front();
      check_value("response tag", 64'(r.tag), 64'(exp_tag_q.pop_front()));
      check_value("response data", r.data, exp_data_q.pop_front());
    end
  endtask

  // Write ends with its credit pulse, then the slave word is inspected
  task automatic wait_write_done(input logic [OFS_W-1:0] ofs, input logic [DATA_W-1:0] data);
    int n;
    n = 0;
    while ((req_credits != REQ_CREDITS) && (n < TIMEOUT))
    begin
      @(posedge pClk);
      n++;
    end
    if (req_credits != REQ_CREDITS)
    begin
      report_timeout("window write never returned its request credit");
      return;
    end
    check_value($sformatf("slave word at byte address %h", {ofs - WIN_BASE, 2'b00}),
                i_slave.mem[8'(ofs - WIN_BASE)], data);
  endtask

  task automatic run_step(input step_t s);
    int n_q;
    int n_exp;
    case (s.op)
      OP_WR:
      begin
        send_req(1'b1, s.ofs, s.data, '0);
        if (!aborted && (s.ofs >= WIN_BASE))
          wait_write_done(s.ofs, s.data);
      end
      OP_RD, OP_RDN:
      begin
        send_req(1'b0, s.ofs, '0, s.exp);
        collect_rsps();
        if (s.op == OP_RD)
          return_credit();   // Keep the AFU at its full credit count
      end
      OP_RDQ:
        send_req(1'b0, s.ofs, '0, s.exp);
      OP_DRAIN:
      begin
        n_q   = exp_tag_q.size();
        n_exp = (n_q < RSP_CREDITS) ? n_q : RSP_CREDITS;
        repeat (s.data[15:0]) @(posedge pClk);
        check_value("responses before any credit return", 64'(rsp_q.size()), 64'(n_exp));
        for (int k = 0; k < n_q; k++)
          return_credit();
        collect_rsps();
      end
      OP_SRST:
      begin
        @(posedge pClk);
        soft_reset <= 1'b1;
        @(posedge pClk);
        soft_reset <= 1'b0;
        repeat (3) @(posedge pClk);
        rsp_credits = RSP_CREDITS;   // AFU back to its initial credits
      end
      default:
      begin
        errors++;
        aborted = 1'b1;
        $display("step uses an operation the table does not define");
      end
    endcase
  endtask

  // ************************************************************
  // Main sequence
  // ************************************************************
  initial
  begin
    int  err_before;
    int  tests_run;
    op_e op;
    pClk         = 1'b0;
    arst_n       = 1'b0;
    soft_reset   = 1'b0;
    rx           = '0;
    next_tag     = 9'h040;
    errors       = 0;
    failed_steps = 0;
    req_credits  = REQ_CREDITS;
    rsp_credits  = RSP_CREDITS;
    req_pulses   = 0;
    win_reqs     = 0;
    aborted      = 1'b0;
    tests_run    = 0;
    steps = '{
      '{OP_RD,    16'h0000, 64'h0,    AFU_ID},   // Identifier
      '{OP_WR,    16'h0002, D_SCR,    64'h0},
      '{OP_RD,    16'h0002, 64'h0,    D_SCR},
      '{OP_RD,    16'h0007, 64'h0,    64'h0},    // Unmapped reads as 0
      '{OP_WR,    16'h0000, ~D_SCR,   64'h0},    // ID is read only
      '{OP_RD,    16'h0000, 64'h0,    AFU_ID},
      '{OP_WR,    16'h0100, D_A,      64'h0},
      '{OP_WR,    16'h0105, D_B,      64'h0},
      '{OP_WR,    16'h01FF, D_C,      64'h0},
      '{OP_RD,    16'h0100, 64'h0,    D_A},
      '{OP_RD,    16'h01FF, 64'h0,    D_C},
      '{OP_RD,    16'h0105, 64'h0,    D_B},
      '{OP_RD,    16'h0180, 64'h0,    D_PAT},    // Never written
      '{OP_RDQ,   16'h0100, 64'h0,    D_A},      // Four reads, no credits back
      '{OP_RDQ,   16'h0105, 64'h0,    D_B},
      '{OP_RDQ,   16'h01FF, 64'h0,    D_C},
      '{OP_RDQ,   16'h0180, 64'h0,    D_PAT},
      '{OP_DRAIN, 16'h0000, 64'd120,  64'h0},
      '{OP_RDN,   16'h0002, 64'h0,    D_SCR},    // AFU left one credit short
      '{OP_SRST,  16'h0000, 64'h0,    64'h0},
      '{OP_RD,    16'h0002, 64'h0,    64'h0},    // Scratch cleared
      '{OP_RDQ,   16'h0105, 64'h0,    D_B},
      '{OP_RDQ,   16'h0100, 64'h0,    D_A},
      '{OP_RDQ,   16'h01FF, 64'h0,    D_C},
      '{OP_DRAIN, 16'h0000, 64'd120,  64'h0},    // Full credits again after reset
      '{OP_RD,    16'h0000, 64'h0,    AFU_ID}
    };
    repeat (3) @(posedge pClk);
    arst_n <= 1'b1;
    @(negedge pClk);
    check_value("tx valid after reset", 64'(tx.mmio.valid), 64'd0);
    check_value("req_credit_return after reset", 64'(tx.req_credit_return), 64'd0);
    check_value("avs_read after reset", 64'(avs_read), 64'd0);
    check_value("avs_write after reset", 64'(avs_write), 64'd0);
    $display("test reset values: %s", (errors == 0) ? "ok" : "failed");
    for (int i = 0; (i < N_STEPS) && !aborted; i++)
    begin
      err_before = errors;
      op         = steps[i].op;
      run_step(steps[i]);
      tests_run++;
      if (errors != err_before)
        failed_steps++;
      $display("test %0d %s offset %h: %s", i, op.name(), steps[i].ofs,
               (errors == err_before) ? "ok" : "failed");
    end
    // One credit pulse per accepted window request, nothing left over
    check_value("request credit pulses", 64'(req_pulses), 64'(win_reqs));
    check_value("slave bad access flag", 64'(bad_access), 64'd0);
    check_value("unexpected extra responses", 64'(rsp_q.size()), 64'd0);
    $display("tests run %0d, failed %0d, check errors %0d", tests_run, failed_steps, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== filelist.f ====
src/ccip_pkg.sv
src/req_fifo.sv
src/mmio_decoder.sv
src/avmm_master.sv
src/tx_arbiter.sv
src/afu.sv
src/ccip_std_afu.sv
dv/avmm_slave_model.sv
dv/tb_ccip_std_afu.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator, run the testbench, and decide on the log contents
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_ccip_std_afu -f filelist.f \
  -Mdir obj_dir -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "TEST RESULT: PASS" sim.log && exit 0 || exit 1
